// File: pipe_cpu.f
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/data_mem.sv
logic/pipe_datapath.sv
logic/cpu_top.sv
dv/pipe_cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pipe_cpu testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary -j 0 --top-module pipe_cpu_tb -f pipe_cpu.f \
        -Mdir obj_dir -o pipe_cpu_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pipe_cpu_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $log_file"
    exit 1
fi

// File: dv/pipe_cpu_tb.sv
module pipe_cpu_tb
    import cpu_pkg::*;
();

    localparam int n_tests = 6;

    logic  clk;
    logic  reset;
    word_t imem_data;
    word_t imem_addr;
    word_t num_inst;
    word_t output_port;
    logic  wwd_valid;
    logic  is_halted;

    string test_name [n_tests] = '{"r-type arithmetic", "immediates", "memory round trip",
                                   "halt", "reset between tests", "spacing rule"};

    // programs padded with nop, hand assembled
    word_t prog_tbl [n_tests][16] = '{
        '{16'h6112, 16'h62F0, 16'h0000, 16'h5534,   // lhi r1,12  lhi r2,f0  nop  ori r1,r1,34
          16'h5A0F, 16'h0000, 16'h0000, 16'hF6C0,   // ori r2,r2,0f  nop  nop  add r3,r1,r2
          16'hF601, 16'hF642, 16'hF683, 16'hFC1C,   // sub r0  and r1  orr r2  wwd r3
          16'hF01C, 16'hF41C, 16'hF81C, 16'hF01D},  // wwd r0  wwd r1  wwd r2  hlt
        '{16'h41FD, 16'h5280, 16'h63A5, 16'hF41C,   // adi r1,r0,-3  ori r2,r0,80  lhi r3,a5
          16'hF81C, 16'hFC1C, 16'h457F, 16'h0000,   // wwd r2  wwd r3  adi r1,r1,7f  nop
          16'h0000, 16'hF41C, 16'hF01D, 16'h0000,   // nop  wwd r1  hlt
          16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h615A, 16'h4210, 16'h0000, 16'h55C3,   // lhi r1,5a  adi r2,r0,10  nop  ori r1,r1,c3
          16'h0000, 16'h0000, 16'h8900, 16'h8AFF,   // nop  nop  swd r1,[r2]  swd r2,[r2-1]
          16'h7B00, 16'h78FF, 16'h0000, 16'hFC1C,   // lwd r3,[r2]  lwd r0,[r2-1]  nop  wwd r3
          16'hF01C, 16'hF01D, 16'h0000, 16'h0000},  // wwd r0  hlt
        '{16'h4121, 16'h0000, 16'h0000, 16'hF41C,   // adi r1,r0,21  nop  nop  wwd r1
          16'hF01D, 16'hF41C, 16'h4201, 16'h0000,   // hlt  wwd r1  adi r2 (never issued)
          16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'hF41C, 16'hF81C, 16'hFC1C, 16'hF01D,   // registers never written
          16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h4105, 16'h0000, 16'h0000, 16'hF580,   // adi r1,r0,05  nop  nop  add r2,r1,r1
          16'h4333, 16'h5040, 16'hF81C, 16'hFC1C,   // adi r3,r0,33  ori r0,r0,40  wwd r2  wwd r3
          16'hF01C, 16'hF01D, 16'h0000, 16'h0000,   // wwd r0  hlt
          16'h0000, 16'h0000, 16'h0000, 16'h0000}
    };

    int    prog_len [n_tests]  = '{16, 11, 14, 7, 4, 10};
    word_t exp_wwd [n_tests][4] = '{
        '{16'h0243, 16'h2225, 16'h1004, 16'hF23F},
        '{16'hFFFD, 16'h0080, 16'hA500, 16'h007C},
        '{16'h5AC3, 16'h0010, 16'h0000, 16'h0000},
        '{16'h0021, 16'h0000, 16'h0000, 16'h0000},
        '{16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h000A, 16'h0033, 16'h0040, 16'h0000}
    };
    int    exp_wwd_n [n_tests] = '{4, 4, 2, 1, 3, 3};
    word_t exp_num [n_tests]   = '{16'd13, 16'd9, 16'd10, 16'd3, 16'd4, 16'd8};
    word_t exp_pc [n_tests]    = '{16'd16, 16'd11, 16'd14, 16'd5, 16'd4, 16'd10};  // one past hlt

    word_t cur_prog [16];
    word_t cur_len = '0;
    word_t seen_wwd [$];
    int    cycle_count = 0;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;

    cpu_top cpu_top_i (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .num_inst    (num_inst),
        .output_port (output_port),
        .wwd_valid   (wwd_valid),
        .is_halted   (is_halted)
    );

    // instruction port, nop past the end
    assign imem_data = (imem_addr < cur_len) ? cur_prog[imem_addr[3:0]] : '0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (wwd_valid) seen_wwd.push_back(output_port);
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, got);
            test_errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (9) @(posedge clk);
        @(negedge clk);
        seen_wwd.delete();
        check_count("num_inst", num_inst, 16'd0);
        check_flag("is_halted", is_halted, 1'b0);
        @(posedge clk);
        reset <= 1'b0;
    endtask

    // run limit is the sum of the per-test limits
    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < n_tests; i++) limit += 2 * prog_len[i] + 20;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped: %0d cycles used, which is over the limit", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int cycles;
        reset <= 1'b1;
        tests_passed = 0;
        tests_failed = 0;
        for (int t = 0; t < n_tests; t++) begin
            test_errors = 0;
            cur_prog = prog_tbl[t];
            cur_len  = 16'(prog_len[t]);
            apply_reset();
            cycles = 0;
            while (!is_halted && cycles < 2 * prog_len[t] + 20) begin
                @(negedge clk);
                cycles++;
            end
            if (!is_halted) begin
                $display("test %s: processor did not halt within %0d cycles",
                         test_name[t], cycles);
                test_errors++;
            end
            repeat (4) @(negedge clk);    // catch any late wwd pulse
            if (seen_wwd.size() != exp_wwd_n[t]) begin
                $display("test %s: expected %0d WWD outputs but saw %0d",
                         test_name[t], exp_wwd_n[t], seen_wwd.size());
                test_errors++;
            end
            for (int k = 0; k < exp_wwd_n[t] && k < seen_wwd.size(); k++) begin
                check_word("output_port", seen_wwd[k], exp_wwd[t][k]);
            end
            // last wwd value is held
            check_word("output_port", output_port, exp_wwd[t][exp_wwd_n[t] - 1]);
            check_word("imem_addr", imem_addr, exp_pc[t]);
            check_count("num_inst", num_inst, exp_num[t]);
            check_flag("is_halted", is_halted, 1'b1);
            if (test_errors == 0) begin
                $display("test %0d %s: pass", t, test_name[t]);
                tests_passed++;
            end else begin
                $display("test %0d %s: fail with %0d errors", t, test_name[t], test_errors);
                tests_failed++;
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", n_tests, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: logic/cpu_top.sv
module cpu_top
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t imem_data,
    output word_t imem_addr,
    output word_t num_inst,
    output word_t output_port,
    output logic  wwd_valid,
    output logic  is_halted
);

    logic  dmem_read;
    logic  dmem_write;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;

    pipe_datapath pipe_datapath_i (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .dmem_rdata  (dmem_rdata),
        .imem_addr   (imem_addr),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .num_inst    (num_inst),
        .output_port (output_port),
        .wwd_valid   (wwd_valid),
        .is_halted   (is_halted)
    );

    data_mem data_mem_i (
        .clk   (clk),
        .read  (dmem_read),
        .write (dmem_write),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

endmodule

// File: logic/pipe_datapath.sv
module pipe_datapath
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t imem_data,
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output logic  dmem_read,
    output logic  dmem_write,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output word_t num_inst,
    output word_t output_port,
    output logic  wwd_valid,
    output logic  is_halted
);

    word_t    pc;
    word_t    if_instr;
    logic     if_valid;
    logic     halting;      // hlt has passed decode
    logic     stop_fetch;

    reg_idx_t dec_rs;
    reg_idx_t dec_rt;
    reg_idx_t dec_dest;
    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    word_t    rf_rdata1;
    word_t    rf_rdata2;

    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    word_t    alu_b;
    word_t    alu_result;
    word_t    wb_data;

    // fetch
    assign stop_fetch = halting | (dec_ctrl.valid & dec_ctrl.is_halt);
    assign imem_addr  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            if_valid <= 1'b0;
            halting  <= 1'b0;
        end else begin
            if (!stop_fetch) pc <= pc + 16'd1;
            if_valid <= !stop_fetch;    // bubbles once halting
            if (dec_ctrl.valid && dec_ctrl.is_halt) halting <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if_instr <= imem_data;
    end

    // decode
    decode_unit decode_unit_i (
        .instr       (if_instr),
        .instr_valid (if_valid),
        .rs          (dec_rs),
        .rt          (dec_rt),
        .dest        (dec_dest),
        .ctrl        (dec_ctrl),
        .imm         (dec_imm)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec_rs),
        .raddr2 (dec_rt),
        .waddr  (mem_wb.dest),
        .wdata  (wb_data),
        .wen    (mem_wb.ctrl.reg_write),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // execute
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rdata2;

    alu alu_i (
        .a      (id_ex.rdata1),
        .b      (alu_b),
        .op     (id_ex.ctrl.alu_op),
        .result (alu_result)
    );

    // memory
    assign dmem_read  = ex_mem.ctrl.mem_read;
    assign dmem_write = ex_mem.ctrl.mem_write;
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;

    // writeback
    assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

    // stage registers, only ctrl is cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex.ctrl  <= ctrl_bubble;
            ex_mem.ctrl <= ctrl_bubble;
            mem_wb.ctrl <= ctrl_bubble;
        end else begin
            id_ex.ctrl  <= dec_ctrl;
            ex_mem.ctrl <= id_ex.ctrl;
            mem_wb.ctrl <= ex_mem.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.rdata1 <= rf_rdata1;
        id_ex.rdata2 <= rf_rdata2;    // rt, store data for swd
        id_ex.imm    <= dec_imm;
        id_ex.dest   <= dec_dest;

        ex_mem.alu_result <= alu_result;
        ex_mem.store_data <= id_ex.rdata2;
        ex_mem.dest       <= id_ex.dest;
        ex_mem.wwd_data   <= id_ex.rdata1;

        mem_wb.mem_data   <= dmem_rdata;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.dest       <= ex_mem.dest;
        mem_wb.wwd_data   <= ex_mem.wwd_data;
    end

    // retire side
    always_ff @(posedge clk) begin
        if (reset) begin
            num_inst    <= '0;
            output_port <= '0;
            wwd_valid   <= 1'b0;
            is_halted   <= 1'b0;
        end else begin
            wwd_valid <= mem_wb.ctrl.is_wwd;
            if (mem_wb.ctrl.valid) num_inst <= num_inst + 16'd1;
            if (mem_wb.ctrl.is_wwd) output_port <= mem_wb.wwd_data;
            if (mem_wb.ctrl.is_halt) is_halted <= 1'b1;   // sticky until reset
        end
    end

endmodule

// File: logic/data_mem.sv
module data_mem
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  read,
    input  logic  write,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [dmem_depth];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr[$clog2(dmem_depth)-1:0]] <= wdata;
        end
    end

    // low address bits only
    assign rdata = read ? mem[addr[$clog2(dmem_depth)-1:0]] : '0;

endmodule

// File: logic/decode_unit.sv
module decode_unit
    import cpu_pkg::*;
(
    input  word_t    instr,
    input  logic     instr_valid,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output reg_idx_t dest,
    output ctrl_t    ctrl,
    output word_t    imm
);

    opcode_e            opcode;
    func_e              func;
    logic [imm_w-1:0]   imm_field;
    ctrl_t              c;

    assign opcode    = opcode_e'(instr[15:12]);
    assign func      = func_e'(instr[5:0]);
    assign imm_field = instr[imm_w-1:0];

    assign rs = instr[rs_hi:rs_lo];
    assign rt = instr[rt_hi:rt_lo];

    // r-type writes rd, everything else rt
    assign dest = (opcode == op_rtype) ? instr[rd_hi:rd_lo] : rt;

    always_comb begin
        c = ctrl_bubble;
        c.valid = 1'b1;
        case (opcode)
            op_rtype: begin
                case (func)
                    fn_add: begin c.reg_write = 1'b1; c.alu_op = alu_add; end
                    fn_sub: begin c.reg_write = 1'b1; c.alu_op = alu_sub; end
                    fn_and: begin c.reg_write = 1'b1; c.alu_op = alu_and; end
                    fn_orr: begin c.reg_write = 1'b1; c.alu_op = alu_or; end
                    fn_wwd: c.is_wwd = 1'b1;
                    fn_hlt: c.is_halt = 1'b1;
                    default: c = ctrl_bubble;
                endcase
            end
            op_adi, op_ori, op_lhi: begin
                c.reg_write   = 1'b1;
                c.alu_src_imm = 1'b1;
                c.alu_op      = (opcode == op_adi) ? alu_add :
                                (opcode == op_ori) ? alu_or : alu_pass_b;
            end
            op_lwd: begin
                c.reg_write   = 1'b1;
                c.alu_src_imm = 1'b1;
                c.mem_read    = 1'b1;
                c.mem_to_reg  = 1'b1;
            end
            op_swd: begin
                c.alu_src_imm = 1'b1;
                c.mem_write   = 1'b1;
            end
            default: c = ctrl_bubble;   // nop and unknown codes
        endcase
        ctrl = instr_valid ? c : ctrl_bubble;
    end

    always_comb begin
        case (opcode)
            op_ori:  imm = {{(16-imm_w){1'b0}}, imm_field};
            op_lhi:  imm = {imm_field, {(16-imm_w){1'b0}}};
            default: imm = {{(16-imm_w){imm_field[imm_w-1]}}, imm_field};
        endcase
    end

endmodule

// File: logic/reg_file.sv
module reg_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  logic     wen,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rdata1 = (wen && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: logic/alu.sv
module alu
    import cpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result
);

    always_comb begin
        case (op)
            alu_add:    result = a + b;     // wraps at 16 bits
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_pass_b: result = b;         // lhi
            default:    result = '0;
        endcase
    end

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    // instr[15:12]
    typedef enum logic [3:0] {
        op_nop   = 4'd0,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15
    } opcode_e;

    // instr[5:0], r-type only
    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic    valid;       // not a bubble
        logic    reg_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    is_wwd;
        logic    is_halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rdata1;
        word_t    rdata2;
        word_t    imm;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
        word_t    wwd_data;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    mem_data;
        word_t    alu_result;
        reg_idx_t dest;
        word_t    wwd_data;
    } mem_wb_t;

    localparam int rs_hi = 11;
    localparam int rs_lo = 10;
    localparam int rt_hi = 9;
    localparam int rt_lo = 8;
    localparam int rd_hi = 7;
    localparam int rd_lo = 6;
    localparam int imm_w = 8;
    localparam int dmem_depth = 256;

    localparam ctrl_t ctrl_bubble = '0;

endpackage
